// File: Bender.yml
package:
  name: bmu_exec_stage

sources:
  - rtl/bmuPkg.sv
  - rtl/aluDecoder.sv
  - rtl/baseAlu.sv
  - rtl/zbbUnit.sv
  - rtl/clmulUnit.sv
  - rtl/bitManipAlu.sv
  - rtl/execStage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tbExec.sv

// File: dv/aluRefModel.svh
////////////////////////////////////////////////////////////
// Expected result and illegal flag per RV32I and Zb* rules
////////////////////////////////////////////////////////////
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

typedef struct packed {
  logic        illegal;
  logic [31:0] value;
} expectT;

// Full 64-bit carry-less product
function automatic logic [63:0] carrylessProduct(input logic [31:0] x, input logic [31:0] y);
  logic [63:0] p;
  p = '0;
  for (int i = 0; i < 32; i++) begin
    if (y[i]) p = p ^ ({32'b0, x} << i);
  end
  return p;
endfunction

function automatic expectT expectedResult(input logic [31:0] ins, input logic [31:0] x,
                                          input logic [31:0] rs2);
  logic [6:0]  op;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [4:0]  sel;      // rs2 field, picks unary ops
  logic [31:0] y;
  logic [4:0]  sh;
  logic [63:0] cl;
  logic [10:0] key;
  expectT      e;
  int          n;
  op  = ins[6:0];
  f3  = ins[14:12];
  f7  = ins[31:25];
  sel = ins[24:20];
  y   = (op == bmuPkg::OPCODE_OPIMM) ? {{20{ins[31]}}, ins[31:20]} : rs2;
  sh  = y[4:0];          // Shift amount or bit index
  cl  = carrylessProduct(x, y);
  key = {op == bmuPkg::OPCODE_OPIMM, f7, f3};
  e   = '0;
  if (op == bmuPkg::OPCODE_OPIMM && f3 != 3'b001 && f3 != 3'b101) begin
    case (f3)                                    // Plain immediate ops
      3'b000:  e.value = x + y;
      3'b010:  e.value = 32'($signed(x) < $signed(y));
      3'b011:  e.value = 32'(x < y);
      3'b100:  e.value = x ^ y;
      3'b110:  e.value = x | y;
      default: e.value = x & y;
    endcase
  end else if (op == bmuPkg::OPCODE_OP || op == bmuPkg::OPCODE_OPIMM) begin
    case (key)
      {1'b0, 7'h00, 3'b000}: e.value = x + y;
      {1'b0, 7'h20, 3'b000}: e.value = x - y;
      {1'b0, 7'h00, 3'b010}: e.value = 32'($signed(x) < $signed(y));
      {1'b0, 7'h00, 3'b011}: e.value = 32'(x < y);
      {1'b0, 7'h00, 3'b100}: e.value = x ^ y;
      {1'b0, 7'h00, 3'b110}: e.value = x | y;
      {1'b0, 7'h00, 3'b111}: e.value = x & y;
      {1'b0, 7'h20, 3'b100}: e.value = ~(x ^ y);    // xnor
      {1'b0, 7'h20, 3'b110}: e.value = x | ~y;      // orn
      {1'b0, 7'h20, 3'b111}: e.value = x & ~y;      // andn
      {1'b0, 7'h00, 3'b001}, {1'b1, 7'h00, 3'b001}: e.value = x << sh;
      {1'b0, 7'h00, 3'b101}, {1'b1, 7'h00, 3'b101}: e.value = x >> sh;
      {1'b0, 7'h20, 3'b101}, {1'b1, 7'h20, 3'b101}: e.value = $signed(x) >>> sh;
      {1'b0, 7'h10, 3'b010}: e.value = (x << 1) + y;
      {1'b0, 7'h10, 3'b100}: e.value = (x << 2) + y;
      {1'b0, 7'h10, 3'b110}: e.value = (x << 3) + y;
      {1'b0, 7'h05, 3'b001}: e.value = cl[31:0];    // clmul
      {1'b0, 7'h05, 3'b010}: e.value = cl[62:31];   // clmulr
      {1'b0, 7'h05, 3'b011}: e.value = cl[63:32];   // clmulh
      {1'b0, 7'h05, 3'b100}: e.value = ($signed(x) < $signed(y)) ? x : y;
      {1'b0, 7'h05, 3'b101}: e.value = (x < y) ? x : y;
      {1'b0, 7'h05, 3'b110}: e.value = ($signed(x) < $signed(y)) ? y : x;
      {1'b0, 7'h05, 3'b111}: e.value = (x < y) ? y : x;
      {1'b0, 7'h30, 3'b001}: e.value = (x << sh) | (x >> (32 - sh));
      {1'b0, 7'h30, 3'b101}, {1'b1, 7'h30, 3'b101}: e.value = (x >> sh) | (x << (32 - sh));
      {1'b0, 7'h14, 3'b001}, {1'b1, 7'h14, 3'b001}: e.value = x | (32'd1 << sh);
      {1'b0, 7'h24, 3'b001}, {1'b1, 7'h24, 3'b001}: e.value = x & ~(32'd1 << sh);
      {1'b0, 7'h34, 3'b001}, {1'b1, 7'h34, 3'b001}: e.value = x ^ (32'd1 << sh);
      {1'b0, 7'h24, 3'b101}, {1'b1, 7'h24, 3'b101}: e.value = 32'(x[sh]);
      {1'b0, 7'h04, 3'b100}: begin                  // zext.h, rs2 field must be 0
        if (sel == 5'd0) e.value = {16'b0, x[15:0]};
        else e.illegal = 1'b1;
      end
      {1'b1, 7'h14, 3'b101}: begin                  // orc.b
        if (sel == 5'd7) begin
          e.value = {{8{|x[31:24]}}, {8{|x[23:16]}}, {8{|x[15:8]}}, {8{|x[7:0]}}};
        end else begin
          e.illegal = 1'b1;
        end
      end
      {1'b1, 7'h34, 3'b101}: begin                  // rev8
        if (sel == 5'd24) e.value = {x[7:0], x[15:8], x[23:16], x[31:24]};
        else e.illegal = 1'b1;
      end
      {1'b1, 7'h30, 3'b001}: begin                  // Unary Zbb group
        n = 0;
        case (sel)
          5'd0: begin
            while (n < 32 && !x[31-n]) n++;         // clz
            e.value = 32'(n);
          end
          5'd1: begin
            while (n < 32 && !x[n]) n++;            // ctz
            e.value = 32'(n);
          end
          5'd2:    e.value = 32'($countones(x));
          5'd4:    e.value = {{24{x[7]}}, x[7:0]};
          5'd5:    e.value = {{16{x[15]}}, x[15:0]};
          default: e.illegal = 1'b1;
        endcase
      end
      default: e.illegal = 1'b1;
    endcase
  end else begin
    e.illegal = 1'b1;                               // Not OP or OP-IMM
  end
  if (e.illegal) e.value = '0;
  return e;
endfunction

`endif

// File: dv/tbExec.sv
////////////////////////////////////////////////////////////
// Testbench for execStage with reference model and scoreboard
////////////////////////////////////////////////////////////
`default_nettype none

module tbExec;
  timeunit 1ns;
  timeprecision 100ps;

  `include "aluRefModel.svh"

  localparam int TIMEOUT = 200;   // Cycles

  typedef struct packed {
    logic [2:0]  testId;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } itemT;

  logic              clk;
  logic              rstN;
  logic              instrValid;
  bmuPkg::instrWordT instr;
  logic [31:0]       rs1Val;
  logic [31:0]       rs2Val;
  logic              resultValid;
  logic [31:0]       result;
  logic              illegal;

  itemT pending[$];  // In-flight items in issue order
  int   issued;
  int   checked;

  execStage uut (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .rs1Val     (rs1Val),
    .rs2Val     (rs2Val),
    .resultValid(resultValid),
    .result     (result),
    .illegal    (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic failRun(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped on first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expVal, actVal);
      failRun("Value check failed");
    end
  endtask

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd0:    return "latency";
      3'd1:    return "rv32i";
      3'd2:    return "zba_zbs";
      3'd3:    return "zbb";
      3'd4:    return "zbc";
      default: return "illegal";
    endcase
  endfunction

  function automatic logic [31:0] encodeReg(input logic [6:0] f7, input logic [4:0] rs2f,
                                            input logic [2:0] f3);
    return {f7, rs2f, 5'd1, f3, 5'd2, bmuPkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] encodeImm(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, bmuPkg::OPCODE_OPIMM};
  endfunction

  // Edge values mixed with random words
  function automatic logic [31:0] pickOperand();
    case ($urandom_range(0, 7))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return 32'h7fff_ffff;
      4:       return 32'h0000_0001;
      default: return 32'($urandom);
    endcase
  endfunction

  function automatic logic [6:0] zbsFunct7(input int j);
    case (j)
      0:       return 7'h14;        // bset
      1:       return 7'h24;        // bclr
      default: return 7'h34;        // binv
    endcase
  endfunction

  function automatic logic [31:0] zbbInstr(input int k, input logic [4:0] sh);
    case (k)
      0:       return encodeReg(7'h20, 5'd2, 3'b111);   // andn
      1:       return encodeReg(7'h20, 5'd2, 3'b110);   // orn
      2:       return encodeReg(7'h20, 5'd2, 3'b100);   // xnor
      3:       return encodeImm(12'h600, 3'b001);       // clz
      4:       return encodeImm(12'h601, 3'b001);       // ctz
      5:       return encodeImm(12'h602, 3'b001);       // cpop
      6:       return encodeReg(7'h05, 5'd2, 3'b100);   // min
      7:       return encodeReg(7'h05, 5'd2, 3'b101);   // minu
      8:       return encodeReg(7'h05, 5'd2, 3'b110);   // max
      9:       return encodeReg(7'h05, 5'd2, 3'b111);   // maxu
      10:      return encodeImm(12'h604, 3'b001);       // sext.b
      11:      return encodeImm(12'h605, 3'b001);       // sext.h
      12:      return encodeReg(7'h04, 5'd0, 3'b100);   // zext.h
      13:      return encodeReg(7'h30, 5'd2, 3'b001);   // rol
      14:      return encodeReg(7'h30, 5'd2, 3'b101);   // ror
      15:      return encodeImm({7'h30, sh}, 3'b101);   // rori
      16:      return encodeImm(12'h287, 3'b101);       // orc.b
      default: return encodeImm(12'h698, 3'b101);       // rev8
    endcase
  endfunction

  // Drives one strobe 1 ns after the edge
  // Back-to-back calls give back-to-back strobes
  task automatic issue(input logic [2:0] testId, input logic [31:0] ins,
                       input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    #1;
    instrValid = 1'b1;
    instr      = ins;
    rs1Val     = a;
    rs2Val     = b;
    pending.push_back('{testId, ins, a, b});
    issued++;
  endtask

  task automatic drain();
    int cycles;
    @(posedge clk);
    #1;
    instrValid = 1'b0;
    cycles     = 0;
    while (pending.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) failRun("Timeout waiting for outstanding results");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard samples on the falling edge where outputs are settled

  initial begin : compareProc
    itemT   item;
    expectT exp;
    forever begin
      @(negedge clk);
      if (rstN && resultValid) begin
        if (pending.size() == 0) failRun("Result valid with nothing in flight");
        item = pending.pop_front();
        exp  = expectedResult(item.instr, item.rs1, item.rs2);
        checkValue({testName(item.testId), " illegal"}, 32'(exp.illegal), 32'(illegal));
        checkValue(testName(item.testId), exp.value, result);
        checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin : mainProc
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  idx;
    int          k;
    int          cycles;
    void'($urandom(32'h71cd504b));
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    rs1Val     = '0;
    rs2Val     = '0;
    issued     = 0;
    checked    = 0;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Reset values then a single add and its latency
    @(negedge clk);
    checkValue("reset valid", 32'd0, 32'(resultValid));
    checkValue("reset illegal", 32'd0, 32'(illegal));
    checkValue("reset result", 32'd0, result);
    issue(3'd0, encodeReg(7'h00, 5'd2, 3'b000), 32'd5, 32'd7);
    cycles = 0;
    while (!resultValid) begin
      @(posedge clk);
      #1;
      instrValid = 1'b0;                            // Single strobe
      cycles++;
      if (cycles > TIMEOUT) failRun("Timeout waiting for the first result");
    end
    checkValue("latency", 32'd1, 32'(cycles));
    drain();

    // RV32I register and immediate forms
    for (int i = 0; i < 200; i++) begin
      f3 = 3'($urandom_range(0, 7));
      if ($urandom_range(0, 1) == 1) begin
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        ins = encodeReg(f7, 5'd2, f3);
      end else if (f3 == 3'b001 || f3 == 3'b101) begin
        f7  = (f3 == 3'b101 && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        ins = encodeImm({f7, 5'($urandom_range(0, 31))}, f3);
      end else begin
        ins = encodeImm(12'($urandom), f3);
      end
      issue(3'd1, ins, pickOperand(), pickOperand());
    end
    drain();

    // Zba sums and Zbs register and immediate forms
    for (int i = 0; i < 132; i++) begin
      k   = i % 11;
      idx = (i % 3 == 0) ? 5'd31 : 5'($urandom);  // Top bit index often
      b   = {27'($urandom), idx};
      if (k < 3) ins = encodeReg(7'h10, 5'd2, 3'((k + 1) * 2));
      else if (k < 6) ins = encodeReg(zbsFunct7(k - 3), 5'd2, 3'b001);
      else if (k == 6) ins = encodeReg(7'h24, 5'd2, 3'b101);
      else if (k < 10) ins = encodeImm({zbsFunct7(k - 7), idx}, 3'b001);
      else ins = encodeImm({7'h24, idx}, 3'b101);
      issue(3'd2, ins, pickOperand(), b);
    end
    drain();

    // Every Zbb op with corner operands in rounds 0 to 3
    for (int r = 0; r < 10; r++) begin
      for (int j = 0; j < 18; j++) begin
        a = pickOperand();
        b = pickOperand();
        case (r)
          0: begin
            a = '0;
            b = '0;
          end
          1: b = a;                                 // Equal
          2: begin
            a = a | 32'h8000_0000;                  // Signs differ
            b = b & 32'h7fff_ffff;
          end
          3: begin
            a = a & 32'h7fff_ffff;
            b = b | 32'h8000_0000;
          end
          default: ;
        endcase
        issue(3'd3, zbbInstr(j, 5'($urandom)), a, b);
      end
    end
    drain();

    // Carry-less multiply on random then single-bit operands
    for (int i = 0; i < 60; i++) begin
      a = (i < 30) ? 32'($urandom) : (32'd1 << $urandom_range(0, 31));
      b = (i < 30) ? 32'($urandom) : (32'd1 << $urandom_range(0, 31));
      issue(3'd4, encodeReg(7'h05, 5'd2, 3'((i % 3) + 1)), a, b);
    end
    drain();

    // Bad encodings
    for (int i = 0; i < 24; i++) begin
      case (i % 6)
        0:       ins = encodeReg(7'h01, 5'd2, 3'($urandom));  // M extension
        1:       ins = encodeReg(7'h20, 5'd2, 3'b010);
        2:       ins = encodeReg(7'h05, 5'd2, 3'b000);
        3:       ins = encodeImm({7'h30, 5'd3}, 3'b001);      // Unknown unary
        4:       ins = encodeImm({7'h14, 5'd6}, 3'b101);      // orc.b with wrong rs2
        default: ins = {25'($urandom), 7'b0000011};           // Load opcode
      endcase
      issue(3'd5, ins, pickOperand(), pickOperand());
    end
    drain();

    if (checked != issued) begin
      failRun("Number of results differs from number of strobes");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: rtl/aluDecoder.sv
////////////////////////////////////////////////////////////
// Instruction decoder for RV32I and Zba/Zbb/Zbc/Zbs ALU ops
////////////////////////////////////////////////////////////
`default_nettype none

module aluDecoder (
  input  bmuPkg::instrWordT       instr,
  output bmuPkg::aluCtrlT         ctrl,
  output logic [bmuPkg::XLEN-1:0] immVal,
  output logic                    illegal
);

  logic [6:0] opcode;
  logic [6:0] funct7;   // imm[11:5] for immediate shifts
  logic [2:0] funct3;
  logic [4:0] rs2;
  logic       isOp;
  logic       isImm;

  assign opcode = instr.rType.opcode;
  assign funct7 = instr.rType.funct7;
  assign funct3 = instr.rType.funct3;
  assign rs2    = instr.rType.rs2;
  assign isOp   = (opcode == bmuPkg::OPCODE_OP);
  assign isImm  = (opcode == bmuPkg::OPCODE_OPIMM);

  assign immVal = {{(bmuPkg::XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};

  always_comb begin
    ctrl        = '0;
    ctrl.useImm = isImm;
    ctrl.aluOp  = funct3;            // Base op straight from funct3
    illegal     = 1'b0;
    if (!isOp && !isImm) begin
      illegal = 1'b1;                // Unsupported opcode
    end else if (isOp || funct3 == 3'b001 || funct3 == 3'b101) begin
      // Register ops and immediate shift-class ops share funct7 decode
      case (funct7)
        7'b0000000: ;                // Base ops, defaults hold
        7'b0100000: begin            // sub, sra, xnor, orn, andn
          ctrl.subtract   = 1'b1;
          ctrl.shiftArith = 1'b1;
          ctrl.bmuActive  = funct3 inside {3'b100, 3'b110, 3'b111};
          illegal         = funct3 inside {3'b001, 3'b010, 3'b011};
        end
        7'b0010000: begin            // sh1add, sh2add, sh3add
          ctrl.preShift    = 1'b1;
          ctrl.preShiftAmt = funct3[2:1];
          ctrl.aluOp       = 3'b000;
          ctrl.bSelect     = bmuPkg::BSEL_FULL;
          ctrl.bmuActive   = 1'b1;
          illegal          = funct3[0] | (funct3[2:1] == 2'b00);
        end
        7'b0000101: begin            // Carry-less multiply, min/max
          ctrl.bmuActive = 1'b1;
          ctrl.clmulOp   = funct3[1:0];
          ctrl.bSelect   = funct3[2] ? bmuPkg::BSEL_ZBB : bmuPkg::BSEL_ZBC;
          case (funct3[1:0])
            2'b00:   ctrl.zbbOp = bmuPkg::ZBB_MIN;
            2'b01:   ctrl.zbbOp = bmuPkg::ZBB_MINU;
            2'b10:   ctrl.zbbOp = bmuPkg::ZBB_MAX;
            default: ctrl.zbbOp = bmuPkg::ZBB_MAXU;
          endcase
          illegal = isImm | (funct3 == 3'b000);
        end
        7'b0110000: begin            // Rotates, plus unary ops in imm form
          ctrl.bmuActive = 1'b1;
          ctrl.bSelect   = bmuPkg::BSEL_ZBB;
          if (isImm && funct3 == 3'b001) begin
            case (rs2)
              5'b00000: ctrl.zbbOp = bmuPkg::ZBB_CLZ;
              5'b00001: ctrl.zbbOp = bmuPkg::ZBB_CTZ;
              5'b00010: ctrl.zbbOp = bmuPkg::ZBB_CPOP;
              5'b00100: ctrl.zbbOp = bmuPkg::ZBB_SEXTB;
              5'b00101: ctrl.zbbOp = bmuPkg::ZBB_SEXTH;
              default:  illegal = 1'b1;
            endcase
          end else begin
            ctrl.zbbOp = funct3[2] ? bmuPkg::ZBB_ROR : bmuPkg::ZBB_ROL;
            illegal    = (funct3 != 3'b001) && (funct3 != 3'b101);
          end
        end
        7'b0010100, 7'b0100100, 7'b0110100: begin  // Zbs group, orc.b, rev8
          ctrl.bmuActive = 1'b1;
          ctrl.bSelect   = bmuPkg::BSEL_FULL;
          ctrl.mask      = (funct3 == 3'b001);    // bext stays unmasked
          case (funct7[5:4])
            2'b01:   ctrl.maskOp = bmuPkg::MASK_SET;
            2'b10:   ctrl.maskOp = funct3[2] ? bmuPkg::MASK_EXT : bmuPkg::MASK_CLR;
            default: ctrl.maskOp = bmuPkg::MASK_INV;
          endcase
          if (funct3 == 3'b101 && funct7[5:4] != 2'b10) begin
            ctrl.bSelect = bmuPkg::BSEL_ZBB;
            ctrl.zbbOp   = funct7[5] ? bmuPkg::ZBB_REV8 : bmuPkg::ZBB_ORCB;
            illegal      = !isImm || rs2 != (funct7[5] ? 5'b11000 : 5'b00111);
          end else begin
            illegal = (funct3 != 3'b001) && (funct3 != 3'b101);
          end
        end
        7'b0000100: begin            // zext.h
          ctrl.bmuActive = 1'b1;
          ctrl.bSelect   = bmuPkg::BSEL_ZBB;
          ctrl.zbbOp     = bmuPkg::ZBB_ZEXTH;
          illegal        = isImm | (funct3 != 3'b100) | (rs2 != 5'b00000);
        end
        default: illegal = 1'b1;     // Unknown funct7
      endcase
    end
    if (illegal) ctrl.bmuActive = 1'b0;  // Keep BMU quiet on bad words
  end

endmodule

`default_nettype wire

// File: rtl/baseAlu.sv
////////////////////////////////////////////////////////////
// Base ALU with adder, comparator, logic and shifter
////////////////////////////////////////////////////////////
`default_nettype none

module baseAlu (
  input  logic [bmuPkg::XLEN-1:0] a,             // Conditionally shifted A
  input  logic [bmuPkg::XLEN-1:0] b,             // Conditionally masked B
  input  bmuPkg::aluCtrlT         ctrl,
  output logic [bmuPkg::XLEN-1:0] preAluResult,  // RV32I result
  output logic [bmuPkg::XLEN-1:0] fullResult,    // Raw adder or Zbs logic result
  output logic                    lt,
  output logic                    ltu
);

  logic [bmuPkg::XLEN-1:0]   condInvB;
  logic [bmuPkg::XLEN-1:0]   sum;
  logic [bmuPkg::XLEN-1:0]   shiftLeft;
  logic [bmuPkg::XLEN:0]     shiftRight;   // Extra MSB carries the sign fill
  logic [bmuPkg::SHAMTW-1:0] shamt;

  assign shamt    = b[bmuPkg::SHAMTW-1:0];
  assign condInvB = ctrl.subtract ? ~b : b;      // sub, andn, orn, xnor
  assign sum      = a + condInvB + {{(bmuPkg::XLEN-1){1'b0}}, ctrl.subtract};

  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  ////////////////////////////////////////////////////////////
  // Shifter

  assign shiftLeft  = a << shamt;
  assign shiftRight = $signed({ctrl.shiftArith & a[bmuPkg::XLEN-1], a}) >>> shamt;

  ////////////////////////////////////////////////////////////
  // Result muxes

  always_comb begin
    case (ctrl.aluOp)
      3'b000:  preAluResult = sum;                  // add, sub
      3'b001:  preAluResult = shiftLeft;
      3'b010:  preAluResult = {{(bmuPkg::XLEN-1){1'b0}}, lt};
      3'b011:  preAluResult = {{(bmuPkg::XLEN-1){1'b0}}, ltu};
      3'b100:  preAluResult = a ^ condInvB;         // xor, xnor
      3'b101:  preAluResult = shiftRight[bmuPkg::XLEN-1:0];
      3'b110:  preAluResult = a | condInvB;         // or, orn
      default: preAluResult = a & condInvB;         // and, andn
    endcase
  end

  // Zbs uses the one-hot B here, everything else takes the sum
  always_comb begin
    fullResult = sum;                               // Zba shNadd
    if (ctrl.mask) begin
      case (ctrl.maskOp)
        bmuPkg::MASK_SET: fullResult = a | b;
        bmuPkg::MASK_CLR: fullResult = a & ~b;
        bmuPkg::MASK_INV: fullResult = a ^ b;
        default:          fullResult = sum;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/bitManipAlu.sv
////////////////////////////////////////////////////////////
// Bit-manipulation ALU with operand prep and result select
////////////////////////////////////////////////////////////
`default_nettype none

module bitManipAlu (
  input  logic [bmuPkg::XLEN-1:0] a,
  input  logic [bmuPkg::XLEN-1:0] b,
  input  bmuPkg::aluCtrlT         ctrl,
  input  logic                    lt,
  input  logic                    ltu,
  input  logic [bmuPkg::XLEN-1:0] preAluResult,
  input  logic [bmuPkg::XLEN-1:0] fullResult,
  output logic [bmuPkg::XLEN-1:0] condMaskB,    // One-hot B for Zbs
  output logic [bmuPkg::XLEN-1:0] condShiftA,   // Pre-shifted A for Zba
  output logic [bmuPkg::XLEN-1:0] aluResult
);

  logic [bmuPkg::XLEN-1:0] aGated;
  logic [bmuPkg::XLEN-1:0] bGated;
  logic [bmuPkg::XLEN-1:0] maskB;
  logic [bmuPkg::XLEN-1:0] extShift;
  logic [bmuPkg::XLEN-1:0] extResult;
  logic [bmuPkg::XLEN-1:0] zbbResult;
  logic [bmuPkg::XLEN-1:0] clmulResult;

  // Idle BMU datapath sees zeros, no toggling
  assign aGated = a & {bmuPkg::XLEN{ctrl.bmuActive}};
  assign bGated = b & {bmuPkg::XLEN{ctrl.bmuActive}};

  ////////////////////////////////////////////////////////////
  // Zbs and Zba operand prep

  assign maskB     = {{(bmuPkg::XLEN-1){1'b0}}, 1'b1} << bGated[bmuPkg::SHAMTW-1:0];
  assign condMaskB = ctrl.mask ? maskB : b;
  assign condShiftA = ctrl.preShift ? (a << ctrl.preShiftAmt) : a;  // 0 to 3 bits

  // bext, indexed bit moved down to bit 0
  assign extShift  = aGated >> bGated[bmuPkg::SHAMTW-1:0];
  assign extResult = {{(bmuPkg::XLEN-1){1'b0}}, extShift[0]};

  ////////////////////////////////////////////////////////////
  // Zbb and Zbc units

  zbbUnit uZbb (
    .a        (aGated),
    .b        (bGated),
    .lt       (lt),
    .ltu      (ltu),
    .zbbOp    (ctrl.zbbOp),
    .zbbResult(zbbResult)
  );

  clmulUnit uClmul (
    .a          (aGated),
    .b          (bGated),
    .clmulOp    (ctrl.clmulOp),
    .clmulResult(clmulResult)
  );

  // Result select
  always_comb begin
    case (ctrl.bSelect)
      bmuPkg::BSEL_BASE: aluResult = preAluResult;
      bmuPkg::BSEL_FULL: begin                  // Zba sums, Zbs logic or extract
        aluResult = (ctrl.maskOp == bmuPkg::MASK_EXT) ? extResult : fullResult;
      end
      bmuPkg::BSEL_ZBB:  aluResult = zbbResult;
      bmuPkg::BSEL_ZBC:  aluResult = clmulResult;
      default:           aluResult = preAluResult;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/bmuPkg.sv
////////////////////////////////////////////////////////////
// Shared width, opcodes, instruction views and ALU controls
////////////////////////////////////////////////////////////
`default_nettype none

package bmuPkg;

  localparam int XLEN   = 32;
  localparam int SHAMTW = $clog2(XLEN);  // Shift amount and bit index width
  localparam int CNTW   = SHAMTW + 1;    // Count width, must hold XLEN

  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;

  // Zbs logic op on the masked B
  localparam logic [1:0] MASK_SET = 2'd0;
  localparam logic [1:0] MASK_CLR = 2'd1;
  localparam logic [1:0] MASK_INV = 2'd2;
  localparam logic [1:0] MASK_EXT = 2'd3;

  // Zbc forms, same as funct3[1:0]
  localparam logic [1:0] CLMUL_LO  = 2'b01;
  localparam logic [1:0] CLMUL_REV = 2'b10;
  localparam logic [1:0] CLMUL_HI  = 2'b11;

  ////////////////////////////////////////////////////////////
  // Instruction word

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;     // Also shamt and unary Zbb selector
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
  } instrWordT;

  ////////////////////////////////////////////////////////////
  // Controls

  typedef enum logic [2:0] {
    BSEL_BASE, BSEL_FULL, BSEL_ZBB, BSEL_ZBC
  } bSelectT;

  typedef enum logic [3:0] {
    ZBB_CLZ, ZBB_CTZ, ZBB_CPOP, ZBB_MIN, ZBB_MINU, ZBB_MAX, ZBB_MAXU,
    ZBB_SEXTB, ZBB_SEXTH, ZBB_ZEXTH, ZBB_ROL, ZBB_ROR, ZBB_ORCB, ZBB_REV8
  } zbbOpT;

  typedef struct packed {
    logic       useImm;      // B from immediate
    logic       subtract;    // Adder subtracts, logic ops invert B
    logic [2:0] aluOp;       // funct3 style base op
    logic       shiftArith;
    logic       mask;        // Zbs one-hot B
    logic [1:0] maskOp;
    logic       preShift;    // Zba
    logic [1:0] preShiftAmt;
    bSelectT    bSelect;
    zbbOpT      zbbOp;
    logic [1:0] clmulOp;
    logic       bmuActive;
  } aluCtrlT;

endpackage

`default_nettype wire

// File: rtl/clmulUnit.sv
////////////////////////////////////////////////////////////
// Zbc carry-less multiply, low, high and reversed forms
////////////////////////////////////////////////////////////
`default_nettype none

module clmulUnit (
  input  logic [bmuPkg::XLEN-1:0] a,
  input  logic [bmuPkg::XLEN-1:0] b,
  input  logic [1:0]              clmulOp,   // Encoded as funct3[1:0]
  output logic [bmuPkg::XLEN-1:0] clmulResult
);

  logic [bmuPkg::XLEN-1:0] aIn;
  logic [bmuPkg::XLEN-1:0] bIn;
  logic [bmuPkg::XLEN-1:0] product;     // Low half only
  logic [bmuPkg::XLEN-1:0] revProduct;

  function automatic logic [bmuPkg::XLEN-1:0] bitRev(input logic [bmuPkg::XLEN-1:0] x);
    logic [bmuPkg::XLEN-1:0] r;
    for (int i = 0; i < bmuPkg::XLEN; i++) r[i] = x[bmuPkg::XLEN-1-i];
    return r;
  endfunction

  // High forms reuse the low product on reversed operands
  assign aIn = clmulOp[1] ? bitRev(a) : a;
  assign bIn = clmulOp[1] ? bitRev(b) : b;

  always_comb begin
    product = '0;
    for (int i = 0; i < bmuPkg::XLEN; i++) begin
      if (bIn[i]) product = product ^ (aIn << i);  // XOR of partial products
    end
  end

  assign revProduct = bitRev(product);             // Bits 62:31 of full product

  always_comb begin
    case (clmulOp)
      bmuPkg::CLMUL_LO:  clmulResult = product;
      bmuPkg::CLMUL_REV: clmulResult = revProduct;
      bmuPkg::CLMUL_HI:  clmulResult = revProduct >> 1;
      default:           clmulResult = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/execStage.sv
////////////////////////////////////////////////////////////
// Execute stage top with decoder, ALUs and result register
////////////////////////////////////////////////////////////
`default_nettype none

module execStage (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    instrValid,   // One-cycle strobe
  input  bmuPkg::instrWordT       instr,
  input  logic [bmuPkg::XLEN-1:0] rs1Val,
  input  logic [bmuPkg::XLEN-1:0] rs2Val,
  output logic                    resultValid,
  output logic [bmuPkg::XLEN-1:0] result,
  output logic                    illegal
);

  bmuPkg::aluCtrlT         ctrl;
  logic [bmuPkg::XLEN-1:0] immVal;
  logic [bmuPkg::XLEN-1:0] opB;
  logic [bmuPkg::XLEN-1:0] condShiftA;
  logic [bmuPkg::XLEN-1:0] condMaskB;
  logic [bmuPkg::XLEN-1:0] preAluResult;
  logic [bmuPkg::XLEN-1:0] fullResult;
  logic [bmuPkg::XLEN-1:0] aluResult;
  logic                    lt;
  logic                    ltu;
  logic                    decIllegal;

  aluDecoder uDecoder (
    .instr  (instr),
    .ctrl   (ctrl),
    .immVal (immVal),
    .illegal(decIllegal)
  );

  assign opB = ctrl.useImm ? immVal : rs2Val;

  baseAlu uBaseAlu (
    .a           (condShiftA),
    .b           (condMaskB),
    .ctrl        (ctrl),
    .preAluResult(preAluResult),
    .fullResult  (fullResult),
    .lt          (lt),
    .ltu         (ltu)
  );

  bitManipAlu uBitManipAlu (
    .a           (rs1Val),
    .b           (opB),
    .ctrl        (ctrl),
    .lt          (lt),
    .ltu         (ltu),
    .preAluResult(preAluResult),
    .fullResult  (fullResult),
    .condMaskB   (condMaskB),
    .condShiftA  (condShiftA),
    .aluResult   (aluResult)
  );

  ////////////////////////////////////////////////////////////
  // Output register, one result per strobe

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      illegal     <= 1'b0;
      result      <= '0;
    end else begin
      resultValid <= instrValid;
      illegal     <= instrValid & decIllegal;
      if (instrValid) result <= decIllegal ? '0 : aluResult;  // Zero on bad word
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  aValidLatency: assert property (@(posedge clk) disable iff (!rstN)
    resultValid == $past(instrValid));

  aIllegalValid: assert property (@(posedge clk) disable iff (!rstN)
    illegal |-> resultValid);

  aInstrKnown: assert property (@(posedge clk) disable iff (!rstN)
    instrValid |-> !$isunknown(instr));

endmodule

`default_nettype wire

// File: rtl/zbbUnit.sv
////////////////////////////////////////////////////////////
// Zbb counts, min/max, extends, rotates, orc.b and rev8
////////////////////////////////////////////////////////////
`default_nettype none

module zbbUnit (
  input  logic [bmuPkg::XLEN-1:0] a,
  input  logic [bmuPkg::XLEN-1:0] b,
  input  logic                    lt,      // Signed a < b
  input  logic                    ltu,     // Unsigned a < b
  input  bmuPkg::zbbOpT           zbbOp,
  output logic [bmuPkg::XLEN-1:0] zbbResult
);

  logic [bmuPkg::CNTW-1:0]     lzCount;
  logic [bmuPkg::CNTW-1:0]     tzCount;
  logic [bmuPkg::CNTW-1:0]     popCount;
  logic [2*bmuPkg::XLEN-1:0]   rotLeft;    // Upper half is rol
  logic [2*bmuPkg::XLEN-1:0]   rotRight;   // Lower half is ror
  logic [bmuPkg::XLEN-1:0]     orcB;
  logic [bmuPkg::XLEN-1:0]     rev8;
  logic [bmuPkg::SHAMTW-1:0]   rotAmt;

  ////////////////////////////////////////////////////////////
  // Counters

  // Zero input leaves both counts at XLEN
  always_comb begin
    lzCount  = bmuPkg::CNTW'(bmuPkg::XLEN);
    tzCount  = bmuPkg::CNTW'(bmuPkg::XLEN);
    popCount = '0;
    for (int i = 0; i < bmuPkg::XLEN; i++) begin
      if (a[i]) lzCount = bmuPkg::CNTW'(bmuPkg::XLEN - 1 - i);  // Highest set bit wins
      if (a[bmuPkg::XLEN-1-i]) tzCount = bmuPkg::CNTW'(bmuPkg::XLEN - 1 - i);
      popCount = popCount + bmuPkg::CNTW'(a[i]);
    end
  end

  // Rotates through a doubled word
  assign rotAmt   = b[bmuPkg::SHAMTW-1:0];
  assign rotLeft  = {a, a} << rotAmt;
  assign rotRight = {a, a} >> rotAmt;

  // Per-byte ops
  for (genvar i = 0; i < bmuPkg::XLEN/8; i++) begin : gByte
    assign orcB[8*i +: 8] = {8{|a[8*i +: 8]}};
    assign rev8[8*i +: 8] = a[bmuPkg::XLEN-8-8*i +: 8];
  end

  ////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    case (zbbOp)
      bmuPkg::ZBB_CLZ:   zbbResult = bmuPkg::XLEN'(lzCount);
      bmuPkg::ZBB_CTZ:   zbbResult = bmuPkg::XLEN'(tzCount);
      bmuPkg::ZBB_CPOP:  zbbResult = bmuPkg::XLEN'(popCount);
      bmuPkg::ZBB_MIN:   zbbResult = lt ? a : b;
      bmuPkg::ZBB_MINU:  zbbResult = ltu ? a : b;
      bmuPkg::ZBB_MAX:   zbbResult = lt ? b : a;
      bmuPkg::ZBB_MAXU:  zbbResult = ltu ? b : a;
      bmuPkg::ZBB_SEXTB: zbbResult = {{(bmuPkg::XLEN-8){a[7]}}, a[7:0]};
      bmuPkg::ZBB_SEXTH: zbbResult = {{(bmuPkg::XLEN-16){a[15]}}, a[15:0]};
      bmuPkg::ZBB_ZEXTH: zbbResult = {{(bmuPkg::XLEN-16){1'b0}}, a[15:0]};
      bmuPkg::ZBB_ROL:   zbbResult = rotLeft[2*bmuPkg::XLEN-1:bmuPkg::XLEN];
      bmuPkg::ZBB_ROR:   zbbResult = rotRight[bmuPkg::XLEN-1:0];
      bmuPkg::ZBB_ORCB:  zbbResult = orcB;
      bmuPkg::ZBB_REV8:  zbbResult = rev8;
      default:           zbbResult = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
rtl/bmuPkg.sv
rtl/aluDecoder.sv
rtl/baseAlu.sv
rtl/zbbUnit.sv
rtl/clmulUnit.sv
rtl/bitManipAlu.sv
rtl/execStage.sv
dv/tbExec.sv
